// File: build.f
+incdir+.
fc_pkg.sv
feat_buffer.sv
pe_lane.sv
fc_loader.sv
fc_engine.sv
fc_top.sv
tb_fc.sv

// File: Bender.yml
package:
  name: fc_layer

sources:
  - files:
      - fc_pkg.sv
      - feat_buffer.sv
      - pe_lane.sv
      - fc_loader.sv
      - fc_engine.sv
      - fc_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_fc.sv

// File: fc_ref.svh
`ifndef FC_REF_SVH
`define FC_REF_SVH

// Expected output words and argmax for one layer as streamed on the input
// Layout is features, then per group one bias word and n_feat weight words
function automatic void ref_layer(input word_t layer[$], input int n_feat,
                                  input int n_groups, output word_t exp_words[$],
                                  output int exp_idx);
  elem_t f;
  elem_t w;
  elem_t b;
  acc_t  s;
  word_t wd;
  int    base;
  int    best;
  int    q;
  exp_words = {};
  exp_idx   = 0;
  best      = -1;
  for (int g = 0; g < n_groups; g++) begin
    base = n_feat / LANES + g * (n_feat + 1);
    wd   = '0;
    for (int i = 0; i < LANES; i++) begin
      b = layer[base][DATA_W*i +: DATA_W];
      s = '0;
      for (int k = 0; k < n_feat; k++) begin
        f = layer[k / LANES][DATA_W*(k % LANES) +: DATA_W];
        w = layer[base + 1 + k][DATA_W*i +: DATA_W];
        s += f * w;
      end
      s += acc_t'(b);
      if (s < 0) begin
        q = 0;
      end else if ((s >>> FRAC_SHIFT) > SAT_MAX) begin
        q = SAT_MAX;
      end else begin
        q = int'(s >>> FRAC_SHIFT);
      end
      wd[DATA_W*i +: DATA_W] = q[DATA_W-1:0];
      // Later index wins a tie
      if (q >= best) begin
        best    = q;
        exp_idx = g * LANES + i;
      end
    end
    exp_words.push_back(wd);
  end
endfunction

// Linear congruential step for stimulus and gap generation
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

`endif

// File: tb_fc.sv
module tb_fc
  import fc_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_FEAT      = 16;
  localparam int N_GROUPS    = 3;
  localparam int MW          = addr_w(N_GROUPS * LANES);
  localparam int FEAT_WORDS  = N_FEAT / LANES;
  localparam int LAYER_WORDS = FEAT_WORDS + N_GROUPS * (N_FEAT + 1);
  localparam int N_LAYERS    = 6;
  localparam int CYCLE_LIMIT = N_LAYERS * 3 * LAYER_WORDS * 4 + 500;
  localparam logic [31:0] SEED = 32'hf8ec1b05;

  `include "fc_ref.svh"

  logic          clk;
  logic          rstn;
  logic          in_valid;
  logic          in_ready;
  word_t         in_data;
  logic          out_valid;
  logic          out_ready;
  word_t         out_data;
  logic          out_last;
  logic          done;
  logic [MW-1:0] max_idx;

  // Words still to send, and results still to be seen
  word_t         in_q [$];
  word_t         exp_q [$];
  logic          last_q [$];
  logic [MW-1:0] idx_q [$];

  logic [31:0]   data_rng;
  logic          gaps_on;
  logic          bp_on;
  int            layers_done;

  fc_top #(
    .N_FEAT   (N_FEAT),
    .N_GROUPS (N_GROUPS)
  ) dut_i (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_last  (out_last),
    .done      (done),
    .max_idx   (max_idx)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_last(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_idx(input string name, input logic [MW-1:0] got,
                           input logic [MW-1:0] exp);
    if (got !== exp) begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Layer construction
  //////////////////////////////////////////////////////////////////////

  task automatic draw(output logic [31:0] r);
    data_rng = lcg_next(data_rng);
    r = data_rng;
  endtask

  // Full range features and biases, small signed weights
  task automatic make_random_layer(output word_t layer[$]);
    logic [31:0] r;
    word_t       wd;
    layer = {};
    for (int n = 0; n < FEAT_WORDS; n++) begin
      draw(r);
      layer.push_back(r);
    end
    for (int g = 0; g < N_GROUPS; g++) begin
      draw(r);
      layer.push_back(r);
      for (int k = 0; k < N_FEAT; k++) begin
        for (int i = 0; i < LANES; i++) begin
          draw(r);
          wd[DATA_W*i +: DATA_W] = {{3{r[20]}}, r[20:16]};
        end
        layer.push_back(wd);
      end
    end
  endtask

  // Zero weights, so each output is its bias shifted, which gives many ties
  task automatic make_tie_layer(output word_t layer[$]);
    logic [31:0] r;
    word_t       bias;
    layer = {};
    for (int n = 0; n < FEAT_WORDS; n++) begin
      draw(r);
      layer.push_back(r);
    end
    for (int g = 0; g < N_GROUPS; g++) begin
      for (int i = 0; i < LANES; i++) begin
        draw(r);
        case (r[31:30] % 3)
          0: bias[DATA_W*i +: DATA_W] = 8'h00;
          1: bias[DATA_W*i +: DATA_W] = 8'h40;
          default: bias[DATA_W*i +: DATA_W] = 8'h7f;
        endcase
      end
      if (g == 0) begin
        bias[7:0] = 8'h7f;
      end
      if (g == 1) begin
        bias[23:16] = 8'h7f;
      end
      layer.push_back(bias);
      for (int k = 0; k < N_FEAT; k++) begin
        layer.push_back('0);
      end
    end
  endtask

  task automatic queue_layer(input word_t layer[$], input word_t exp_w[$], input int exp_i);
    foreach (layer[n]) begin
      in_q.push_back(layer[n]);
    end
    foreach (exp_w[n]) begin
      exp_q.push_back(exp_w[n]);
      last_q.push_back(n == exp_w.size() - 1);
    end
    idx_q.push_back(MW'(exp_i));
  endtask

  task automatic wait_layers(input int n);
    while (layers_done < n) begin
      @(negedge clk);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Input driver, output sink and watchdog
  //////////////////////////////////////////////////////////////////////

  // Valid stays up until the word is taken
  initial begin : drive_input
    logic [31:0] gap_rng;
    word_t       cur;
    logic        busy;
    in_valid = 1'b0;
    in_data  = '0;
    busy     = 1'b0;
    cur      = '0;
    gap_rng  = lcg_next(SEED ^ 32'h0000_5a5a);
    forever begin
      @(negedge clk);
      if (!busy && in_q.size() > 0) begin
        gap_rng = lcg_next(gap_rng);
        if (!(gaps_on && gap_rng[31:30] == 2'b00)) begin
          cur  = in_q.pop_front();
          busy = 1'b1;
        end
      end
      in_valid = busy;
      in_data  = busy ? cur : '0;
      // in_ready is settled since the last rising edge
      if (busy && in_ready) begin
        busy = 1'b0;
      end
    end
  end

  initial begin : compare_output
    logic [31:0] bp_rng;
    logic        done_due;
    out_ready   = 1'b1;
    done_due    = 1'b0;
    layers_done = 0;
    bp_rng      = lcg_next(lcg_next(SEED));
    forever begin
      @(negedge clk);
      out_ready = 1'b1;
      if (bp_on) begin
        bp_rng    = lcg_next(bp_rng);
        out_ready = bp_rng[31];
      end
      // done follows the final handshake by exactly one cycle
      check_flag("done", done, done_due);
      done_due = 1'b0;
      if (done) begin
        check_idx("max_idx", max_idx, idx_q.pop_front());
        layers_done++;
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("output word arrived with no expected word pending");
          abort_run();
        end
        done_due = out_last;
        check_last("out_last", out_last, last_q.pop_front());
        check_word("out_data", out_data, exp_q.pop_front());
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("run did not finish within %0d cycles", CYCLE_LIMIT);
    abort_run();
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main_seq
    word_t layer [$];
    word_t layer2 [$];
    word_t exp_w [$];
    int    exp_i;
    rstn     = 1'b0;
    gaps_on  = 1'b0;
    bp_on    = 1'b0;
    data_rng = SEED;

    for (int c = 0; c < 16; c++) begin
      @(negedge clk);
      check_flag("out_valid", out_valid, 1'b0);
    end
    rstn = 1'b1;
    @(negedge clk);
    check_flag("out_valid", out_valid, 1'b0);
    check_flag("in_ready", in_ready, 1'b1);

    // Random layer at full rate
    make_random_layer(layer);
    ref_layer(layer, N_FEAT, N_GROUPS, exp_w, exp_i);
    queue_layer(layer, exp_w, exp_i);
    wait_layers(1);

    // Features of 10, lanes give -16000, 16000, 325 and 127 per group
    layer = {};
    for (int n = 0; n < FEAT_WORDS; n++) begin
      layer.push_back(32'h0a0a0a0a);
    end
    for (int g = 0; g < N_GROUPS; g++) begin
      layer.push_back(32'h7f050000);
      for (int k = 0; k < N_FEAT; k++) begin
        layer.push_back(32'h0002649c);
      end
    end
    exp_w = {32'h01057f00, 32'h01057f00, 32'h01057f00};
    exp_i = (N_GROUPS - 1) * LANES + 1;
    queue_layer(layer, exp_w, exp_i);
    wait_layers(2);

    // Input gaps and output back-pressure
    gaps_on = 1'b1;
    bp_on   = 1'b1;
    make_random_layer(layer);
    ref_layer(layer, N_FEAT, N_GROUPS, exp_w, exp_i);
    queue_layer(layer, exp_w, exp_i);
    wait_layers(3);
    bp_on = 1'b0;

    make_tie_layer(layer);
    ref_layer(layer, N_FEAT, N_GROUPS, exp_w, exp_i);
    queue_layer(layer, exp_w, exp_i);
    wait_layers(4);

    // Two layers queued together, the second reloads the features
    make_random_layer(layer);
    make_random_layer(layer2);
    ref_layer(layer, N_FEAT, N_GROUPS, exp_w, exp_i);
    queue_layer(layer, exp_w, exp_i);
    ref_layer(layer2, N_FEAT, N_GROUPS, exp_w, exp_i);
    queue_layer(layer2, exp_w, exp_i);
    wait_layers(6);

    repeat (4) @(negedge clk);
    if (in_q.size() != 0 || exp_q.size() != 0 || idx_q.size() != 0) begin
      $display("run ended with input words or expected results left over");
      abort_run();
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

// File: fc_top.sv
module fc_top
  import fc_pkg::*;
#(
  parameter int N_FEAT   = 16,
  parameter int N_GROUPS = 3
) (
  input  logic                               clk,
  input  logic                               rstn,
  input  logic                               in_valid,
  output logic                               in_ready,
  input  word_t                              in_data,
  output logic                               out_valid,
  input  logic                               out_ready,
  output word_t                              out_data,
  output logic                               out_last,
  output logic                               done,
  output logic [addr_w(N_GROUPS*LANES)-1:0]  max_idx
);

  localparam int DEPTH = N_FEAT / LANES;
  localparam int AW    = addr_w(DEPTH);

  logic          wr_en;
  logic [AW-1:0] wr_addr;
  word_t         wr_data;
  logic [AW-1:0] rd_addr;
  word_t         rd_data;
  logic          w_valid;
  logic          w_ready;
  word_t         w_data;
  logic          layer_done;

  fc_loader #(
    .N_FEAT (N_FEAT)
  ) u_loader (
    .clk        (clk),
    .rstn       (rstn),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_data    (in_data),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .w_valid    (w_valid),
    .w_ready    (w_ready),
    .w_data     (w_data),
    .layer_done (layer_done)
  );

  feat_buffer #(
    .DEPTH (DEPTH)
  ) u_buffer (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  fc_engine #(
    .N_FEAT   (N_FEAT),
    .N_GROUPS (N_GROUPS)
  ) u_engine (
    .clk        (clk),
    .rstn       (rstn),
    .w_valid    (w_valid),
    .w_ready    (w_ready),
    .w_data     (w_data),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .layer_done (layer_done),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data),
    .out_last   (out_last),
    .done       (done),
    .max_idx    (max_idx)
  );

endmodule

// File: fc_engine.sv
module fc_engine
  import fc_pkg::*;
#(
  parameter int N_FEAT   = 16,
  parameter int N_GROUPS = 3
) (
  input  logic                                  clk,
  input  logic                                  rstn,
  input  logic                                  w_valid,
  output logic                                  w_ready,
  input  word_t                                 w_data,
  output logic [addr_w(N_FEAT/LANES)-1:0]       rd_addr,
  input  word_t                                 rd_data,
  output logic                                  layer_done,
  output logic                                  out_valid,
  input  logic                                  out_ready,
  output word_t                                 out_data,
  output logic                                  out_last,
  output logic                                  done,
  output logic [addr_w(N_GROUPS*LANES)-1:0]     max_idx
);

  localparam int AW    = addr_w(N_FEAT / LANES);
  localparam int SEL_W = $clog2(LANES);
  localparam int FI_W  = AW + SEL_W;
  localparam int GW    = addr_w(N_GROUPS);
  localparam int MW    = addr_w(N_GROUPS * LANES);
  localparam elem_t MIN_ELEM = {1'b1, {(DATA_W-1){1'b0}}};

  engine_state_e     state;
  logic [FI_W-1:0]   feat_idx;
  logic [GW-1:0]     group_idx;
  logic              addr_stable;
  logic              w_take;
  logic              issue;
  logic              out_hs;
  elem_t             feat_byte;
  word_t             bias_q;
  word_t             quant_word;
  acc_t              lane_sum [LANES];
  logic [LANES-1:0]  lane_valid;
  elem_t             run_val;
  logic [MW-1:0]     run_idx;
  elem_t             best_val;
  logic [MW-1:0]     best_idx;

  // Bias add, clamp at zero, saturate, drop the fraction bits
  function automatic elem_t requant(input acc_t s, input elem_t b);
    acc_t t;
    t = s + acc_t'(b);
    if (t < 0) begin
      return '0;
    end else if ((t >>> FRAC_SHIFT) > SAT_MAX) begin
      return elem_t'(SAT_MAX);
    end
    return elem_t'(t >>> FRAC_SHIFT);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Weight intake and lane issue
  //////////////////////////////////////////////////////////////////////

  // Wait one cycle after each address change for the buffer to catch up
  assign w_ready = addr_stable && (state == ENG_BIAS || state == ENG_MAC);
  assign w_take  = w_valid && w_ready;
  assign issue   = w_take && (state == ENG_MAC);

  assign rd_addr   = feat_idx[FI_W-1:SEL_W];
  assign feat_byte = rd_data[DATA_W*feat_idx[SEL_W-1:0] +: DATA_W];

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    pe_lane u_lane (
      .clk       (clk),
      .rstn      (rstn),
      .issue     (issue),
      .first     (feat_idx == '0),
      .last      (feat_idx == FI_W'(N_FEAT - 1)),
      .feat      (feat_byte),
      .weight    (w_data[DATA_W*i +: DATA_W]),
      .sum       (lane_sum[i]),
      .sum_valid (lane_valid[i])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Output word and argmax
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      quant_word[DATA_W*i +: DATA_W] = requant(lane_sum[i], bias_q[DATA_W*i +: DATA_W]);
    end
  end

  assign out_hs     = out_valid && out_ready;
  assign layer_done = out_hs && out_last;

  // Lane order with >= so a tie moves to the later index
  always_comb begin
    elem_t cand;
    best_val = (group_idx == '0) ? MIN_ELEM : run_val;
    best_idx = run_idx;
    for (int i = 0; i < LANES; i++) begin
      cand = elem_t'(out_data[DATA_W*i +: DATA_W]);
      if (cand >= best_val) begin
        best_val = cand;
        best_idx = MW'(group_idx * LANES + i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (w_take && state == ENG_BIAS) begin
      bias_q <= w_data;
    end
    if (state == ENG_DRAIN && (&lane_valid)) begin
      out_data <= quant_word;
    end
    if (out_hs) begin
      run_val <= best_val;
      run_idx <= best_idx;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Group sequencing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state       <= ENG_BIAS;
      feat_idx    <= '0;
      group_idx   <= '0;
      addr_stable <= 1'b0;
      out_valid   <= 1'b0;
      out_last    <= 1'b0;
      done        <= 1'b0;
      max_idx     <= '0;
    end else begin
      addr_stable <= !w_take;
      done        <= 1'b0;
      case (state)
        ENG_BIAS: begin
          if (w_take) begin
            state <= ENG_MAC;
          end
        end
        ENG_MAC: begin
          if (w_take) begin
            if (feat_idx == FI_W'(N_FEAT - 1)) begin
              feat_idx <= '0;
              state    <= ENG_DRAIN;
            end else begin
              feat_idx <= feat_idx + 1'b1;
            end
          end
        end
        ENG_DRAIN: begin
          if (&lane_valid) begin
            out_valid <= 1'b1;
            out_last  <= (group_idx == GW'(N_GROUPS - 1));
            state     <= ENG_OUT;
          end
        end
        ENG_OUT: begin
          if (out_ready) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            state     <= ENG_BIAS;
            if (out_last) begin
              group_idx <= '0;
              done      <= 1'b1;
              max_idx   <= best_idx;
            end else begin
              group_idx <= group_idx + 1'b1;
            end
          end
        end
        default: state <= ENG_BIAS;
      endcase
    end
  end

endmodule

// File: fc_loader.sv
module fc_loader
  import fc_pkg::*;
#(
  parameter int N_FEAT = 16
) (
  input  logic                               clk,
  input  logic                               rstn,
  // Input stream
  input  logic                               in_valid,
  output logic                               in_ready,
  input  word_t                              in_data,
  // Feature buffer write port
  output logic                               wr_en,
  output logic [addr_w(N_FEAT/LANES)-1:0]    wr_addr,
  output word_t                              wr_data,
  // Bias and weight stream to the engine
  output logic                               w_valid,
  input  logic                               w_ready,
  output word_t                              w_data,
  input  logic                               layer_done
);

  localparam int DEPTH = N_FEAT / LANES;
  localparam int AW    = addr_w(DEPTH);

  loader_state_e   state;
  logic [AW-1:0]   word_cnt;
  logic            feat_en;

  // Feature words are taken freely, the rest follows the engine
  assign in_ready = (state == LOAD_FEAT) ? feat_en : w_ready;

  assign wr_en   = (state == LOAD_FEAT) && in_valid && in_ready;
  assign wr_addr = word_cnt;
  assign wr_data = in_data;

  // Straight pass-through in STREAM
  assign w_valid = (state == STREAM) && in_valid;
  assign w_data  = in_data;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state    <= LOAD_FEAT;
      word_cnt <= '0;
      feat_en  <= 1'b0;
    end else begin
      feat_en <= 1'b1;
      case (state)
        LOAD_FEAT: begin
          if (wr_en) begin
            if (word_cnt == AW'(DEPTH - 1)) begin
              word_cnt <= '0;
              state    <= STREAM;
            end else begin
              word_cnt <= word_cnt + 1'b1;
            end
          end
        end
        STREAM: begin
          // Next layer starts with a fresh feature vector
          if (layer_done) begin
            state <= LOAD_FEAT;
          end
        end
        default: state <= LOAD_FEAT;
      endcase
    end
  end

endmodule

// File: pe_lane.sv
module pe_lane
  import fc_pkg::*;
(
  input  logic  clk,
  input  logic  rstn,
  input  logic  issue,
  input  logic  first,
  input  logic  last,
  input  elem_t feat,
  input  elem_t weight,
  output acc_t  sum,
  output logic  sum_valid
);

  logic [DATA_W-1:0]   mag_a;
  logic [DATA_W-1:0]   mag_b;
  logic [2*DATA_W-1:0] pp_sum;

  // Stage registers
  logic [DATA_W-1:0]   mag_a_s1;
  logic [DATA_W-1:0]   mag_b_s1;
  logic                sign_s1;
  logic                sign_s2;
  logic [2*DATA_W-1:0] mag_prod_s2;
  prod_t               prod_s3;

  // Item tags travelling alongside the data
  logic v1, v2, v3;
  logic f1, f2, f3;
  logic l1, l2, l3;

  //////////////////////////////////////////////////////////////////////
  // Sign-magnitude multiply
  //////////////////////////////////////////////////////////////////////

  // -128 gives magnitude 128, which still fits the unsigned byte
  assign mag_a = feat[DATA_W-1] ? -feat : feat;
  assign mag_b = weight[DATA_W-1] ? -weight : weight;

  // Shift-and-add of the partial products
  always_comb begin
    pp_sum = '0;
    for (int i = 0; i < DATA_W; i++) begin
      if (mag_b_s1[i]) begin
        pp_sum = pp_sum + ({{DATA_W{1'b0}}, mag_a_s1} << i);
      end
    end
  end

  always_ff @(posedge clk) begin
    mag_a_s1    <= mag_a;
    mag_b_s1    <= mag_b;
    sign_s1     <= feat[DATA_W-1] ^ weight[DATA_W-1];
    f1          <= first;
    l1          <= last;
    mag_prod_s2 <= pp_sum;
    sign_s2     <= sign_s1;
    f2          <= f1;
    l2          <= l1;
    prod_s3     <= sign_s2 ? -prod_t'(mag_prod_s2) : prod_t'(mag_prod_s2);
    f3          <= f2;
    l3          <= l2;
  end

  //////////////////////////////////////////////////////////////////////
  // Accumulate
  //////////////////////////////////////////////////////////////////////

  // First product of a neuron starts a new sum
  always_ff @(posedge clk) begin
    if (v3) begin
      if (f3) begin
        sum <= acc_t'(prod_s3);
      end else begin
        sum <= sum + acc_t'(prod_s3);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      v1        <= 1'b0;
      v2        <= 1'b0;
      v3        <= 1'b0;
      sum_valid <= 1'b0;
    end else begin
      v1        <= issue;
      v2        <= v1;
      v3        <= v2;
      sum_valid <= v3 && l3;
    end
  end

endmodule

// File: feat_buffer.sv
module feat_buffer
  import fc_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  logic                      clk,
  input  logic                      wr_en,
  input  logic [addr_w(DEPTH)-1:0]  wr_addr,
  input  word_t                     wr_data,
  input  logic [addr_w(DEPTH)-1:0]  rd_addr,
  output word_t                     rd_data
);

  // One word per four features, reused by every group of the layer
  word_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read, data follows the address by one cycle
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: fc_pkg.sv
package fc_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and fixed-point format
  //////////////////////////////////////////////////////////////////////

  // Lanes per engine, also neurons per group and elements per word
  localparam int LANES  = 4;
  localparam int DATA_W = 8;
  localparam int WORD_W = LANES * DATA_W;
  localparam int ACC_W  = 24;

  // Requantization of the biased sum back to 8 bits
  localparam int FRAC_SHIFT = 6;
  localparam int SAT_MAX    = 127;

  //////////////////////////////////////////////////////////////////////
  // Data types
  //////////////////////////////////////////////////////////////////////

  typedef logic signed [DATA_W-1:0]   elem_t;
  typedef logic        [WORD_W-1:0]   word_t;
  typedef logic signed [ACC_W-1:0]    acc_t;
  typedef logic signed [2*DATA_W-1:0] prod_t;

  // Loader: feature fill, then bias and weight pass-through
  typedef enum logic {
    LOAD_FEAT,
    STREAM
  } loader_state_e;

  typedef enum logic [1:0] {
    ENG_BIAS,
    ENG_MAC,
    ENG_DRAIN,
    ENG_OUT
  } engine_state_e;

  // Index width for a range of depth entries, never below one bit
  function automatic int addr_w(input int depth);
    return (depth > 1) ? $clog2(depth) : 1;
  endfunction

endpackage
